/* verilog/rcc_pkg.sv */
// ========================================
// RCC shared sizes, register offsets,
// kernel source numbers and reset timing
// ========================================

package rcc_pkg;

  // ========================================
  // sizes
  // ========================================

  // number of controlled peripherals
  localparam int NUM_PER = 3;

  // APB bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // kernel source select field, per peripheral
  localparam int KER_SEL_W = 2;

  // HSI, CSI and LSE
  localparam int KER_CLK_SRC_NUM = 3;

  // ========================================
  // kernel source numbers
  // ========================================

  localparam int HSI_IDX = 0;
  localparam int CSI_IDX = 1;
  localparam int LSE_IDX = 2;

  // ========================================
  // register offsets
  // ========================================

  localparam logic [APB_ADDR_W-1:0] C1_ENR_OFS   = 8'h00;
  localparam logic [APB_ADDR_W-1:0] C1_LPENR_OFS = 8'h04;
  localparam logic [APB_ADDR_W-1:0] C2_ENR_OFS   = 8'h08;
  localparam logic [APB_ADDR_W-1:0] C2_LPENR_OFS = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] AMENR_OFS    = 8'h10;
  localparam logic [APB_ADDR_W-1:0] KERSELR_OFS  = 8'h14;
  localparam logic [APB_ADDR_W-1:0] RSTR_OFS     = 8'h18;

  // bus clocks that stay off after a peripheral reset release
  localparam int RST_RELEASE_DELAY = 2;

endpackage

/* verilog/rcc_per_ctrl_if.sv */
// ========================================
// per peripheral register settings,
// register block to clock/reset control
// ========================================

`timescale 1ns/1ps

interface rcc_per_ctrl_if;
  import rcc_pkg::*;

  // cpu enables and low-power enables
  logic                 c1_en;
  logic                 c1_lpen;
  logic                 c2_en;
  logic                 c2_lpen;
  // autonomous mode, D3 only
  logic                 amen;
  logic [KER_SEL_W-1:0] ker_sel;
  // software reset, active low
  logic                 sft_rst_n;

  modport regs (
    output c1_en, c1_lpen, c2_en, c2_lpen, amen, ker_sel, sft_rst_n
  );

  modport per (
    input c1_en, c1_lpen, c2_en, c2_lpen, amen, ker_sel, sft_rst_n
  );

endinterface

/* verilog/rcc_apb_regs.sv */
// ========================================
// APB3 register block of the RCC
// ========================================

`timescale 1ns/1ps

module rcc_apb_regs (
  input  logic                          bus_clk,
  input  logic                          arst_n,
  input  logic [rcc_pkg::APB_ADDR_W-1:0] paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [rcc_pkg::APB_DATA_W-1:0] pwdata,
  output logic [rcc_pkg::APB_DATA_W-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  rcc_per_ctrl_if.regs                  per_ctrl [rcc_pkg::NUM_PER]
);
  import rcc_pkg::*;

  localparam int SEL_BITS = KER_SEL_W * NUM_PER;

  logic [NUM_PER-1:0]  c1_enr;
  logic [NUM_PER-1:0]  c1_lpenr;
  logic [NUM_PER-1:0]  c2_enr;
  logic [NUM_PER-1:0]  c2_lpenr;
  logic [NUM_PER-1:0]  amenr;
  logic [SEL_BITS-1:0] kerselr;
  logic [NUM_PER-1:0]  rstr;

  logic                  access;
  logic                  wr_en;
  logic                  addr_hit;
  logic [APB_DATA_W-1:0] rd_data;

  // ========================================
  // address decode and read mux
  // ========================================

  // access phase, pready is tied high
  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (paddr)
      C1_ENR_OFS:   rd_data[NUM_PER-1:0]  = c1_enr;
      C1_LPENR_OFS: rd_data[NUM_PER-1:0]  = c1_lpenr;
      C2_ENR_OFS:   rd_data[NUM_PER-1:0]  = c2_enr;
      C2_LPENR_OFS: rd_data[NUM_PER-1:0]  = c2_lpenr;
      AMENR_OFS:    rd_data[NUM_PER-1:0]  = amenr;
      KERSELR_OFS:  rd_data[SEL_BITS-1:0] = kerselr;
      RSTR_OFS:     rd_data[NUM_PER-1:0]  = rstr;
      default:      addr_hit = 1'b0;
    endcase
  end

  assign prdata  = rd_data;
  assign pready  = 1'b1;
  assign pslverr = access & ~addr_hit;

  // ========================================
  // register storage
  // ========================================

  // write lands on the edge closing the access phase
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      c1_enr   <= '0;
      c1_lpenr <= '0;
      c2_enr   <= '0;
      c2_lpenr <= '0;
      amenr    <= '0;
      kerselr  <= '0;
      rstr     <= '0;
    end else if (wr_en) begin
      case (paddr)
        C1_ENR_OFS:   c1_enr   <= pwdata[NUM_PER-1:0];
        C1_LPENR_OFS: c1_lpenr <= pwdata[NUM_PER-1:0];
        C2_ENR_OFS:   c2_enr   <= pwdata[NUM_PER-1:0];
        C2_LPENR_OFS: c2_lpenr <= pwdata[NUM_PER-1:0];
        AMENR_OFS:    amenr    <= pwdata[NUM_PER-1:0];
        KERSELR_OFS:  kerselr  <= pwdata[SEL_BITS-1:0];
        RSTR_OFS:     rstr     <= pwdata[NUM_PER-1:0];
        // unmapped, nothing changes
        default: ;
      endcase
    end
  end

  // ========================================
  // fan out to each peripheral
  // ========================================

  for (genvar p = 0; p < NUM_PER; p++) begin : g_per
    assign per_ctrl[p].c1_en     = c1_enr[p];
    assign per_ctrl[p].c1_lpen   = c1_lpenr[p];
    assign per_ctrl[p].c2_en     = c2_enr[p];
    assign per_ctrl[p].c2_lpen   = c2_lpenr[p];
    assign per_ctrl[p].amen      = amenr[p];
    assign per_ctrl[p].ker_sel   = kerselr[KER_SEL_W*p +: KER_SEL_W];
    // RSTR bit set holds the peripheral in reset
    assign per_ctrl[p].sft_rst_n = ~rstr[p];
  end

endmodule

/* verilog/rst_sync_clk_gating.sv */
// ========================================
// glitch-free clock gate with enable sync
// ========================================

`timescale 1ns/1ps

module rst_sync_clk_gating (
  input  logic raw_clk,
  input  logic active,
  input  logic bypass,
  input  logic rst_n,
  output logic gen_clk
);

  logic en_meta;
  logic en_sync;
  logic en_lat;

  // two flop synchronizer in the raw_clk domain
  always_ff @(posedge raw_clk or negedge rst_n) begin
    if (!rst_n) begin
      en_meta <= 1'b0;
      en_sync <= 1'b0;
    end else begin
      en_meta <= active;
      en_sync <= en_meta;
    end
  end

  // enable only moves while raw_clk is low,
  // so no clipped high pulse reaches gen_clk
  always_latch begin
    if (!raw_clk) begin
      en_lat <= en_sync;
    end
  end

  // test mode passes the raw clock straight through
  assign gen_clk = raw_clk & (en_lat | bypass);

endmodule

/* verilog/sync_reset_clk_gate.sv */
// ========================================
// clock hold-off after reset release
// ========================================

`timescale 1ns/1ps

module sync_reset_clk_gate #(
  parameter int DELAY = rcc_pkg::RST_RELEASE_DELAY
) (
  input  logic src_rst_n,
  input  logic i_clk,
  input  logic arcg_on,
  output logic clk_en
);

  // thermometer count of edges since the release
  logic [DELAY-1:0] rel_cnt;

  always_ff @(posedge i_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      rel_cnt <= '0;
    end else begin
      rel_cnt[0] <= 1'b1;
      for (int i = 1; i < DELAY; i++) begin
        rel_cnt[i] <= rel_cnt[i-1];
      end
    end
  end

  // top bit set after DELAY edges
  assign clk_en = ~arcg_on | rel_cnt[DELAY-1];

endmodule

/* verilog/per_ker_clk_rst_control.sv */
// ========================================
// bus clock, kernel clock and reset
// control for one peripheral
// ========================================

`timescale 1ns/1ps

module per_ker_clk_rst_control #(
  parameter int KER_CLK_NUM       = 2,
  parameter bit IS_HSI            = 1'b0,
  parameter bit IS_CSI            = 1'b0,
  parameter bit IS_LSE            = 1'b0,
  parameter bit SUPPORT_LPEN      = 1'b0,
  parameter bit SUPPORT_AMEN      = 1'b0,
  // D3 only, no clock unless requested
  parameter bit D3_DEFAULT_NO_CLK = 1'b0,
  parameter bit ASSIGNED_TO_CPU1  = 1'b0,
  parameter bit ASSIGNED_TO_CPU2  = 1'b0,
  // 1, 2 or 3
  parameter int DOMAIN            = 1
) (
  input  logic                   bus_clk,
  input  logic [KER_CLK_NUM-1:0] ker_src_clks,
  rcc_per_ctrl_if.per            ctrl,
  input  logic                   c1_sleep,
  input  logic                   c1_deepsleep,
  input  logic                   c2_sleep,
  input  logic                   c2_deepsleep,
  input  logic                   d3_deepsleep,
  input  logic                   per_ker_clk_req,
  input  logic                   arcg_on,
  input  logic                   testmode,
  input  logic                   sys_rst_n,
  input  logic                   d1_rst_n,
  input  logic                   d2_rst_n,
  output logic                   per_bus_clk,
  output logic [KER_CLK_NUM-1:0] per_ker_clks,
  output logic                   per_rst_n,
  output logic                   csi_ker_clk_req,
  output logic                   hsi_ker_clk_req
);
  import rcc_pkg::*;

  logic                       c1_lp_ok;
  logic                       c2_lp_ok;
  logic                       c1_bus_en;
  logic                       c2_bus_en;
  logic                       d3_bus_en;
  logic                       rel_en;
  logic                       bus_clk_en;
  logic                       ker_clk_en;
  logic [KER_CLK_SRC_NUM-1:0] src_req;

  // ========================================
  // bus clock enable
  // ========================================

  if (SUPPORT_LPEN) begin : g_lpen
    assign c1_lp_ok = ~c1_sleep | ctrl.c1_lpen;
    assign c2_lp_ok = ~c2_sleep | ctrl.c2_lpen;
  end else begin : g_no_lpen
    assign c1_lp_ok = 1'b1;
    assign c2_lp_ok = 1'b1;
  end

  // implicit assignment acts as a set enable bit
  assign c1_bus_en = (ctrl.c1_en | ASSIGNED_TO_CPU1) & c1_lp_ok & ~c1_deepsleep;
  assign c2_bus_en = (ctrl.c2_en | ASSIGNED_TO_CPU2) & c2_lp_ok & ~c2_deepsleep;

  if (DOMAIN == 3) begin : g_d3
    if (SUPPORT_AMEN) begin : g_amen
      assign d3_bus_en = ctrl.amen & ~d3_deepsleep;
    end else if (D3_DEFAULT_NO_CLK) begin : g_no_clk
      assign d3_bus_en = 1'b0;
    end else begin : g_dflt_clk
      assign d3_bus_en = ~d3_deepsleep;
    end
  end else begin : g_d12
    assign d3_bus_en = 1'b0;
  end

  // clocks stay off shortly after a reset release
  sync_reset_clk_gate #(
    .DELAY(RST_RELEASE_DELAY)
  ) u_rel_gate (
    .src_rst_n(per_rst_n),
    .i_clk    (bus_clk),
    .arcg_on  (arcg_on),
    .clk_en   (rel_en)
  );

  assign bus_clk_en = (c1_bus_en | c2_bus_en | d3_bus_en) & rel_en;

  // ========================================
  // kernel requests
  // ========================================

  if (IS_HSI) begin : g_hsi
    assign src_req[HSI_IDX] = (ctrl.ker_sel == KER_SEL_W'(HSI_IDX)) & per_ker_clk_req;
  end else begin : g_no_hsi
    assign src_req[HSI_IDX] = 1'b0;
  end

  if (IS_CSI) begin : g_csi
    assign src_req[CSI_IDX] = (ctrl.ker_sel == KER_SEL_W'(CSI_IDX)) & per_ker_clk_req;
  end else begin : g_no_csi
    assign src_req[CSI_IDX] = 1'b0;
  end

  // LSE keeps the kernel clock running on its own
  if (IS_LSE) begin : g_lse
    assign src_req[LSE_IDX] = (ctrl.ker_sel == KER_SEL_W'(LSE_IDX));
  end else begin : g_no_lse
    assign src_req[LSE_IDX] = 1'b0;
  end

  assign hsi_ker_clk_req = src_req[HSI_IDX];
  assign csi_ker_clk_req = src_req[CSI_IDX];

  assign ker_clk_en = (bus_clk_en | (|src_req)) & rel_en;

  // ========================================
  // clock gates
  // ========================================

  rst_sync_clk_gating u_bus_gate (
    .raw_clk(bus_clk),
    .active (bus_clk_en),
    .bypass (testmode),
    .rst_n  (per_rst_n),
    .gen_clk(per_bus_clk)
  );

  for (genvar k = 0; k < KER_CLK_NUM; k++) begin : g_ker_gate
    rst_sync_clk_gating u_ker_gate (
      .raw_clk(ker_src_clks[k]),
      .active (ker_clk_en),
      .bypass (testmode),
      .rst_n  (per_rst_n),
      .gen_clk(per_ker_clks[k])
    );
  end

  // ========================================
  // peripheral reset
  // ========================================

  if (DOMAIN == 1) begin : g_rst_d1
    assign per_rst_n = sys_rst_n & d1_rst_n & ctrl.sft_rst_n;
  end else if (DOMAIN == 2) begin : g_rst_d2
    assign per_rst_n = sys_rst_n & d2_rst_n & ctrl.sft_rst_n;
  end else begin : g_rst_d3
    assign per_rst_n = sys_rst_n & ctrl.sft_rst_n;
  end

endmodule

/* verilog/rcc_top.sv */
// ========================================
// RCC top, register block and three
// peripheral clock/reset controls
// ========================================

`timescale 1ns/1ps

module rcc_top (
  input  logic                             bus_clk,
  input  logic                             arst_n,
  input  logic                             d1_rst_n,
  input  logic                             d2_rst_n,
  // APB3 slave
  input  logic [rcc_pkg::APB_ADDR_W-1:0]   paddr,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [rcc_pkg::APB_DATA_W-1:0]   pwdata,
  output logic [rcc_pkg::APB_DATA_W-1:0]   prdata,
  output logic                             pready,
  output logic                             pslverr,
  // low-power states
  input  logic                             c1_sleep,
  input  logic                             c1_deepsleep,
  input  logic                             c2_sleep,
  input  logic                             c2_deepsleep,
  input  logic                             d3_deepsleep,
  input  logic                             per_ker_clk_req,
  input  logic                             arcg_on,
  input  logic                             testmode,
  // kernel source clocks
  input  logic                             hsi_clk,
  input  logic                             csi_clk,
  input  logic                             lse_clk,
  output logic [rcc_pkg::NUM_PER-1:0]      per_bus_clks,
  output logic [2*rcc_pkg::NUM_PER-1:0]    per_ker_clks,
  output logic [rcc_pkg::NUM_PER-1:0]      per_rst_n,
  output logic [rcc_pkg::NUM_PER-1:0]      hsi_ker_clk_req,
  output logic [rcc_pkg::NUM_PER-1:0]      csi_ker_clk_req
);
  import rcc_pkg::*;

  rcc_per_ctrl_if per_ctrl [NUM_PER] ();

  rcc_apb_regs u_regs (
    .bus_clk (bus_clk),
    .arst_n  (arst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .per_ctrl(per_ctrl)
  );

  // peripheral 0, D1 with low-power enables, HSI and CSI
  per_ker_clk_rst_control #(
    .KER_CLK_NUM (2),
    .IS_HSI      (1'b1),
    .IS_CSI      (1'b1),
    .SUPPORT_LPEN(1'b1),
    .DOMAIN      (1)
  ) u_per0 (
    .bus_clk        (bus_clk),
    .ker_src_clks   ({csi_clk, hsi_clk}),
    .ctrl           (per_ctrl[0]),
    .c1_sleep       (c1_sleep),
    .c1_deepsleep   (c1_deepsleep),
    .c2_sleep       (c2_sleep),
    .c2_deepsleep   (c2_deepsleep),
    .d3_deepsleep   (d3_deepsleep),
    .per_ker_clk_req(per_ker_clk_req),
    .arcg_on        (arcg_on),
    .testmode       (testmode),
    .sys_rst_n      (arst_n),
    .d1_rst_n       (d1_rst_n),
    .d2_rst_n       (d2_rst_n),
    .per_bus_clk    (per_bus_clks[0]),
    .per_ker_clks   (per_ker_clks[1:0]),
    .per_rst_n      (per_rst_n[0]),
    .csi_ker_clk_req(csi_ker_clk_req[0]),
    .hsi_ker_clk_req(hsi_ker_clk_req[0])
  );

  // peripheral 1, D2 owned by CPU2, HSI and LSE
  per_ker_clk_rst_control #(
    .KER_CLK_NUM     (2),
    .IS_HSI          (1'b1),
    .IS_LSE          (1'b1),
    .ASSIGNED_TO_CPU2(1'b1),
    .DOMAIN          (2)
  ) u_per1 (
    .bus_clk        (bus_clk),
    .ker_src_clks   ({lse_clk, hsi_clk}),
    .ctrl           (per_ctrl[1]),
    .c1_sleep       (c1_sleep),
    .c1_deepsleep   (c1_deepsleep),
    .c2_sleep       (c2_sleep),
    .c2_deepsleep   (c2_deepsleep),
    .d3_deepsleep   (d3_deepsleep),
    .per_ker_clk_req(per_ker_clk_req),
    .arcg_on        (arcg_on),
    .testmode       (testmode),
    .sys_rst_n      (arst_n),
    .d1_rst_n       (d1_rst_n),
    .d2_rst_n       (d2_rst_n),
    .per_bus_clk    (per_bus_clks[1]),
    .per_ker_clks   (per_ker_clks[3:2]),
    .per_rst_n      (per_rst_n[1]),
    .csi_ker_clk_req(csi_ker_clk_req[1]),
    .hsi_ker_clk_req(hsi_ker_clk_req[1])
  );

  // peripheral 2, D3 with autonomous mode, CSI and LSE
  per_ker_clk_rst_control #(
    .KER_CLK_NUM (2),
    .IS_CSI      (1'b1),
    .IS_LSE      (1'b1),
    .SUPPORT_AMEN(1'b1),
    .DOMAIN      (3)
  ) u_per2 (
    .bus_clk        (bus_clk),
    .ker_src_clks   ({lse_clk, csi_clk}),
    .ctrl           (per_ctrl[2]),
    .c1_sleep       (c1_sleep),
    .c1_deepsleep   (c1_deepsleep),
    .c2_sleep       (c2_sleep),
    .c2_deepsleep   (c2_deepsleep),
    .d3_deepsleep   (d3_deepsleep),
    .per_ker_clk_req(per_ker_clk_req),
    .arcg_on        (arcg_on),
    .testmode       (testmode),
    .sys_rst_n      (arst_n),
    .d1_rst_n       (d1_rst_n),
    .d2_rst_n       (d2_rst_n),
    .per_bus_clk    (per_bus_clks[2]),
    .per_ker_clks   (per_ker_clks[5:4]),
    .per_rst_n      (per_rst_n[2]),
    .csi_ker_clk_req(csi_ker_clk_req[2]),
    .hsi_ker_clk_req(hsi_ker_clk_req[2])
  );

endmodule

/* test/rcc_tb.sv */
// ========================================
// RCC testbench, APB driver, clock
// reference model and checks
// ========================================

`timescale 1ns/1ps

module rcc_tb;
  import rcc_pkg::*;

  localparam int NUM_TESTS = 6;
  // lse gate needs three 120 ns cycles to follow
  localparam int SETTLE = 12;
  localparam int WINDOW = 16;

  logic        bus_clk = 1'b0;
  logic        hsi_clk = 1'b0;
  logic        csi_clk = 1'b0;
  logic        lse_clk = 1'b0;
  logic        arst_n;
  logic        d1_rst_n;
  logic        d2_rst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        c1_sleep;
  logic        c1_deepsleep;
  logic        c2_sleep;
  logic        c2_deepsleep;
  logic        d3_deepsleep;
  logic        per_ker_clk_req;
  logic        arcg_on;
  logic        testmode;
  logic [2:0]  per_bus_clks;
  logic [5:0]  per_ker_clks;
  logic [2:0]  per_rst_n;
  logic [2:0]  hsi_ker_clk_req;
  logic [2:0]  csi_ker_clk_req;

  // register copies as written over APB
  logic [31:0] shadow [7];
  logic [31:0] rng = 32'h7287_4061;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;
  int          win_edges [9];
  int          clk_cnt [9];
  logic [8:0]  gclk;

  always #20 bus_clk = ~bus_clk;
  always #5 hsi_clk = ~hsi_clk;
  always #15 csi_clk = ~csi_clk;
  always #60 lse_clk = ~lse_clk;

  rcc_top i_dut (
    .bus_clk(bus_clk), .arst_n(arst_n), .d1_rst_n(d1_rst_n), .d2_rst_n(d2_rst_n),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .c1_sleep(c1_sleep), .c1_deepsleep(c1_deepsleep), .c2_sleep(c2_sleep),
    .c2_deepsleep(c2_deepsleep), .d3_deepsleep(d3_deepsleep),
    .per_ker_clk_req(per_ker_clk_req), .arcg_on(arcg_on), .testmode(testmode),
    .hsi_clk(hsi_clk), .csi_clk(csi_clk), .lse_clk(lse_clk),
    .per_bus_clks(per_bus_clks), .per_ker_clks(per_ker_clks), .per_rst_n(per_rst_n),
    .hsi_ker_clk_req(hsi_ker_clk_req), .csi_ker_clk_req(csi_ker_clk_req)
  );

  // gated clock edge counters
  // bus clocks in bits 0 to 2 and kernel clocks in bits 3 to 8
  assign gclk = {per_ker_clks, per_bus_clks};

  for (genvar i = 0; i < 9; i++) begin : g_edge_cnt
    int cnt = 0;
    always @(posedge gclk[i]) begin
      cnt <= cnt + 1;
    end
    assign clk_cnt[i] = cnt;
  end

  // ========================================
  // checks
  // ========================================

  ap_pready : assert property (@(posedge bus_clk) pready)
    else begin
      $display("ERR %0t: pready low", $time);
      err_cnt++;
    end

  ap_slverr : assert property (@(posedge bus_clk) pslverr |-> (psel && penable))
    else begin
      $display("ERR %0t: pslverr outside the access phase", $time);
      err_cnt++;
    end

  task automatic expect_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic expect_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s got %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic expect_clk(input string what, input int edges, input bit run);
    assert (run ? edges >= 4 : edges == 0) else begin
      $display("ERR %0t: %s counted %0d edges, expected %s", $time, what, edges,
               run ? "running" : "stopped");
      err_cnt++;
    end
  endtask

  // ========================================
  // reference model
  // ========================================

  function automatic logic [31:0] xorshift32();
    logic [31:0] s;
    s = rng;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng = s;
    return s;
  endfunction

  // meaningful bits with two select bits per peripheral in KERSELR
  function automatic logic [31:0] reg_mask(input int r);
    return (r == 5) ? 32'h3f : 32'h7;
  endfunction

  function automatic bit supports(input int p, input int src);
    case (p)
      0: return src != LSE_IDX;
      1: return src != CSI_IDX;
      default: return src != HSI_IDX;
    endcase
  endfunction

  function automatic bit exp_bus_en(input int p);
    bit lp1;
    bit lp2;
    bit c1;
    bit c2;
    bit d3;
    // only peripheral 0 has low-power enables
    lp1 = (p != 0) || !c1_sleep || shadow[1][p];
    lp2 = (p != 0) || !c2_sleep || shadow[3][p];
    c1 = shadow[0][p] && lp1 && !c1_deepsleep;
    // peripheral 1 belongs to CPU2
    c2 = (shadow[2][p] || p == 1) && lp2 && !c2_deepsleep;
    d3 = (p == 2) && shadow[4][p] && !d3_deepsleep;
    return c1 || c2 || d3;
  endfunction

  function automatic bit exp_req(input int p, input int src);
    logic [1:0] sel;
    sel = shadow[5][2*p +: 2];
    if (!supports(p, src) || sel != 2'(src)) return 1'b0;
    return (src == LSE_IDX) ? 1'b1 : per_ker_clk_req;
  endfunction

  function automatic bit exp_ker_en(input int p);
    return exp_bus_en(p) || exp_req(p, HSI_IDX) || exp_req(p, CSI_IDX) ||
           exp_req(p, LSE_IDX);
  endfunction

  function automatic bit exp_rst_n(input int p);
    bit dom;
    dom = (p == 0) ? d1_rst_n : (p == 1) ? d2_rst_n : 1'b1;
    return arst_n && dom && !shadow[6][p];
  endfunction

  task automatic check_resets();
    for (int p = 0; p < NUM_PER; p++) begin
      expect_bit($sformatf("p%0d per_rst_n", p), per_rst_n[p], exp_rst_n(p));
    end
  endtask

  task automatic check_reqs();
    for (int p = 0; p < NUM_PER; p++) begin
      expect_bit($sformatf("p%0d hsi request", p), hsi_ker_clk_req[p], exp_req(p, HSI_IDX));
      expect_bit($sformatf("p%0d csi request", p), csi_ker_clk_req[p], exp_req(p, CSI_IDX));
    end
  endtask

  // reset rule holds in every cycle once inputs are stable
  always begin
    @(negedge bus_clk);
    #10;
    check_resets();
  end

  // ========================================
  // drivers and measurement
  // ========================================

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge bus_clk);
    paddr = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge bus_clk);
    penable = 1'b1;
    @(negedge bus_clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge bus_clk);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge bus_clk);
    penable = 1'b1;
    @(posedge bus_clk);
    data = prdata;
    err = pslverr;
    @(negedge bus_clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input int r, input logic [31:0] v);
    apb_write(8'(4 * r), v);
    shadow[r] = v & reg_mask(r);
  endtask

  task automatic drive_lp(input logic [31:0] rnd);
    @(negedge bus_clk);
    c1_sleep = rnd[0];
    c1_deepsleep = rnd[1];
    c2_sleep = rnd[2];
    c2_deepsleep = rnd[3];
    d3_deepsleep = rnd[4];
    per_ker_clk_req = rnd[5];
  endtask

  task automatic measure(input int cycles);
    int start [9];
    for (int i = 0; i < 9; i++) start[i] = clk_cnt[i];
    repeat (cycles) @(negedge bus_clk);
    for (int i = 0; i < 9; i++) win_edges[i] = clk_cnt[i] - start[i];
  endtask

  // assumes any reset release lies well in the past
  task automatic check_clocks();
    bit run;
    repeat (SETTLE) @(negedge bus_clk);
    measure(WINDOW);
    check_reqs();
    for (int p = 0; p < NUM_PER; p++) begin
      run = testmode || (exp_rst_n(p) && exp_bus_en(p));
      expect_clk($sformatf("p%0d bus clock", p), win_edges[p], run);
      run = testmode || (exp_rst_n(p) && exp_ker_en(p));
      for (int k = 0; k < 2; k++) begin
        expect_clk($sformatf("p%0d kernel clock %0d", p, k), win_edges[3 + 2*p + k], run);
      end
    end
  endtask

  // ========================================
  // tests
  // ========================================

  task automatic test_regs();
    logic [31:0] rd;
    logic        err;
    logic [7:0]  bad_addr [4] = '{8'h1c, 8'h02, 8'h80, 8'hfc};
    for (int r = 0; r < 7; r++) begin
      repeat (3) begin
        write_reg(r, xorshift32());
        apb_read(8'(4 * r), rd, err);
        expect_word($sformatf("reg 0x%0h", 4 * r), rd, shadow[r]);
        expect_bit("pslverr on mapped read", err, 1'b0);
      end
    end
    foreach (bad_addr[i]) begin
      apb_write(bad_addr[i], xorshift32());
      apb_read(bad_addr[i], rd, err);
      expect_word("unmapped read", rd, 32'h0);
      expect_bit("pslverr on unmapped read", err, 1'b1);
    end
    for (int r = 0; r < 7; r++) begin
      apb_read(8'(4 * r), rd, err);
      expect_word($sformatf("reg 0x%0h after unmapped writes", 4 * r), rd, shadow[r]);
    end
  endtask

  task automatic test_bus_en();
    write_reg(6, 32'h0);
    repeat (10) begin
      for (int r = 0; r < 6; r++) write_reg(r, xorshift32());
      drive_lp(xorshift32());
      arcg_on = rng[6];
      check_clocks();
    end
    // peripheral 1 runs with c2_en clear and peripheral 2 on amen
    for (int r = 0; r < 6; r++) write_reg(r, 32'h0);
    write_reg(4, 32'h4);
    drive_lp(32'h0);
    check_clocks();
    drive_lp(32'h10);
    check_clocks();
  endtask

  task automatic test_reset();
    logic [31:0] rnd;
    repeat (12) begin
      rnd = xorshift32();
      @(negedge bus_clk);
      d1_rst_n = rnd[0];
      d2_rst_n = rnd[1];
      #1;
      check_resets();
      write_reg(6, rnd >> 4);
      #1;
      check_resets();
    end
    // global reset also clears every register
    @(negedge bus_clk);
    arst_n = 1'b0;
    for (int r = 0; r < 7; r++) shadow[r] = 32'h0;
    #1;
    check_resets();
    @(negedge bus_clk);
    arst_n = 1'b1;
    d1_rst_n = 1'b1;
    d2_rst_n = 1'b1;
    #1;
    check_resets();
  endtask

  task automatic test_kernel();
    logic [31:0] rnd;
    repeat (8) begin
      rnd = xorshift32();
      write_reg(5, rnd);
      @(negedge bus_clk);
      per_ker_clk_req = rnd[8];
      #1;
      check_reqs();
    end
    // LSE selected on 1 and 2 with their bus clocks off
    for (int r = 0; r < 5; r++) write_reg(r, 32'h0);
    write_reg(5, 32'h28);
    drive_lp(32'h08);
    check_clocks();
    expect_clk("p1 bus clock off", win_edges[1], 1'b0);
    expect_clk("p2 bus clock off", win_edges[2], 1'b0);
    expect_clk("p1 lse kernel clock", win_edges[6], 1'b1);
    expect_clk("p2 lse kernel clock", win_edges[8], 1'b1);
  endtask

  task automatic test_release();
    @(negedge bus_clk);
    arcg_on = 1'b1;
    for (int r = 0; r < 6; r++) write_reg(r, 32'h0);
    write_reg(0, 32'h1);
    drive_lp(32'h0);
    check_clocks();
    write_reg(6, 32'h1);
    check_clocks();
    write_reg(6, 32'h0);
    // first counted edge comes 6 bus cycles after the release edge
    repeat (5) @(negedge bus_clk);
    measure(8);
    expect_word("p0 bus edges after release", 32'(win_edges[0]), 32'd8);
  endtask

  task automatic test_testmode();
    @(negedge bus_clk);
    testmode = 1'b1;
    for (int r = 0; r < 7; r++) write_reg(r, xorshift32());
    drive_lp(xorshift32());
    check_clocks();
    @(negedge bus_clk);
    testmode = 1'b0;
    write_reg(6, 32'h0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt != errs_before) fail_cnt++;
    $display("test %0d %s: %s", test_cnt, name,
             (err_cnt == errs_before) ? "ok" : "failed");
  endtask

  // ========================================
  // sequence and watchdog
  // ========================================

  initial begin
    int errs;
    arst_n = 1'b0;
    d1_rst_n = 1'b1;
    d2_rst_n = 1'b1;
    paddr = 8'h0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = 32'h0;
    c1_sleep = 1'b0;
    c1_deepsleep = 1'b0;
    c2_sleep = 1'b0;
    c2_deepsleep = 1'b0;
    d3_deepsleep = 1'b0;
    per_ker_clk_req = 1'b0;
    arcg_on = 1'b0;
    testmode = 1'b0;
    for (int r = 0; r < 7; r++) shadow[r] = 32'h0;
    repeat (5) @(posedge bus_clk);
    @(negedge bus_clk);
    arst_n = 1'b1;

    errs = err_cnt;
    test_regs();
    report_test("register access", errs);
    errs = err_cnt;
    test_bus_en();
    report_test("bus clock enable", errs);
    errs = err_cnt;
    test_reset();
    report_test("peripheral reset", errs);
    errs = err_cnt;
    test_kernel();
    report_test("kernel requests and clocks", errs);
    errs = err_cnt;
    test_release();
    report_test("release after reset", errs);
    errs = err_cnt;
    test_testmode();
    report_test("test mode", errs);

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge bus_clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* sim.f */
verilog/rcc_pkg.sv
verilog/rcc_per_ctrl_if.sv
verilog/rcc_apb_regs.sv
verilog/rst_sync_clk_gating.sv
verilog/sync_reset_clk_gate.sv
verilog/per_ker_clk_rst_control.sv
verilog/rcc_top.sv
test/rcc_tb.sv

/* Makefile */
# Verilator build for the RCC testbench

VERILATOR ?= verilator
TOP       ?= rcc_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, the status comes from the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
